// File: rtl/ooo_pkg.sv
package ooo_pkg;

  // Datapath and tag widths.
  localparam int xlen = 32;
  localparam int tag_w = 6;
  localparam int num_phys_regs = 64;
  localparam int inst_num_w = 32;

  // Reservation station geometry.
  localparam int rs_depth = 8;
  localparam int rs_idx_w = $clog2(rs_depth);

  // Shift amount width, taken from the low bits of operand b.
  localparam int shamt_w = 5;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sra  = 4'd7,  // Arithmetic shift, sign fills from the top.
    op_slt  = 4'd8,  // Signed compare.
    op_sltu = 4'd9   // Unsigned compare.
  } alu_op_e;

endpackage

// File: rtl/issue_if.sv
`timescale 1ns/10ps

interface issue_if import ooo_pkg::*; ();

  logic                  valid;
  logic [inst_num_w-1:0] inst_num;
  alu_op_e               op;
  logic                  src1_pc;  // Operand a comes from the PC.
  logic                  src2_imm; // Operand b comes from the immediate.
  logic [tag_w-1:0]      tag1;
  logic [tag_w-1:0]      tag2;
  logic [tag_w-1:0]      rd;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       imm;

  modport issuer (
    output valid, inst_num, op, src1_pc, src2_imm, tag1, tag2, rd, pc, imm
  );

  modport executor (
    input valid, inst_num, op, src1_pc, src2_imm, tag1, tag2, rd, pc, imm
  );

endinterface

// File: rtl/result_bus_if.sv
`timescale 1ns/10ps

interface result_bus_if import ooo_pkg::*; ();

  logic                  valid;
  logic [tag_w-1:0]      tag;
  logic [xlen-1:0]       data;
  logic [inst_num_w-1:0] inst_num;

  modport producer (
    output valid, tag, data, inst_num
  );

  modport consumer (
    input valid, tag, data, inst_num
  );

endinterface

// File: rtl/alu_rs.sv
`timescale 1ns/10ps

module alu_rs import ooo_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  flush,
  input  logic                  dispatch_valid,
  input  logic [inst_num_w-1:0] dispatch_inst_num,
  input  alu_op_e               dispatch_op,
  input  logic                  dispatch_src1_pc,
  input  logic                  dispatch_src2_imm,
  input  logic [tag_w-1:0]      dispatch_tag1,
  input  logic                  dispatch_rdy1,
  input  logic [tag_w-1:0]      dispatch_tag2,
  input  logic                  dispatch_rdy2,
  input  logic [tag_w-1:0]      dispatch_rd,
  input  logic [xlen-1:0]       dispatch_pc,
  input  logic [xlen-1:0]       dispatch_imm,
  output logic                  dispatch_ready,
  issue_if.issuer               issue,
  result_bus_if.consumer        alu_bus,
  result_bus_if.consumer        ext_bus
);

  logic [rs_depth-1:0]   busy;
  logic [rs_depth-1:0]   rdy1;
  logic [rs_depth-1:0]   rdy2;
  logic [tag_w-1:0]      tag1 [rs_depth];
  logic [tag_w-1:0]      tag2 [rs_depth];

  logic [inst_num_w-1:0] e_inst_num [rs_depth];
  alu_op_e               e_op [rs_depth];
  logic [rs_depth-1:0]   e_src1_pc;
  logic [rs_depth-1:0]   e_src2_imm;
  logic [tag_w-1:0]      e_rd [rs_depth];
  logic [xlen-1:0]       e_pc [rs_depth];
  logic [xlen-1:0]       e_imm [rs_depth];

  logic [rs_idx_w-1:0]   free_idx;
  logic                  free_found;
  logic [rs_idx_w-1:0]   sel_idx;
  logic                  sel_found;
  logic                  dispatch_fire;
  logic                  disp_hit1;
  logic                  disp_hit2;

  // True when either result bus is writing tag t this cycle.
  function automatic logic woken(input logic [tag_w-1:0] t);
    return (alu_bus.valid && (alu_bus.tag == t)) || (ext_bus.valid && (ext_bus.tag == t));
  endfunction

  // Scan from the top so the lowest index is the one left standing.
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    sel_found  = 1'b0;
    sel_idx    = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = rs_idx_w'(i);
      end
      if (busy[i] && rdy1[i] && rdy2[i]) begin
        sel_found = 1'b1;
        sel_idx   = rs_idx_w'(i);
      end
    end
  end

  assign dispatch_ready = free_found;  // Depends on busy flops only.
  assign dispatch_fire  = dispatch_valid && dispatch_ready;

  // A source produced in the dispatch cycle would otherwise miss its wakeup.
  assign disp_hit1 = dispatch_rdy1 || woken(dispatch_tag1);
  assign disp_hit2 = dispatch_rdy2 || woken(dispatch_tag2);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy        <= '0;
      rdy1        <= '0;
      rdy2        <= '0;
      issue.valid <= 1'b0;
    end else if (flush) begin
      busy        <= '0;
      issue.valid <= 1'b0;
    end else begin
      for (int i = 0; i < rs_depth; i++) begin
        if (busy[i] && !rdy1[i] && woken(tag1[i])) begin
          rdy1[i] <= 1'b1;
        end
        if (busy[i] && !rdy2[i] && woken(tag2[i])) begin
          rdy2[i] <= 1'b1;
        end
      end
      if (sel_found) begin
        busy[sel_idx] <= 1'b0;
      end
      // The free slot is never the selected one, since selection needs busy.
      if (dispatch_fire) begin
        busy[free_idx] <= 1'b1;
        rdy1[free_idx] <= disp_hit1;
        rdy2[free_idx] <= disp_hit2;
      end
      issue.valid <= sel_found;
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch_fire) begin
      e_inst_num[free_idx] <= dispatch_inst_num;
      e_op[free_idx]       <= dispatch_op;
      e_src1_pc[free_idx]  <= dispatch_src1_pc;
      e_src2_imm[free_idx] <= dispatch_src2_imm;
      tag1[free_idx]       <= dispatch_tag1;
      tag2[free_idx]       <= dispatch_tag2;
      e_rd[free_idx]       <= dispatch_rd;
      e_pc[free_idx]       <= dispatch_pc;
      e_imm[free_idx]      <= dispatch_imm;
    end
    issue.inst_num <= e_inst_num[sel_idx];  // Qualified by issue.valid downstream.
    issue.op       <= e_op[sel_idx];
    issue.src1_pc  <= e_src1_pc[sel_idx];
    issue.src2_imm <= e_src2_imm[sel_idx];
    issue.tag1     <= tag1[sel_idx];
    issue.tag2     <= tag2[sel_idx];
    issue.rd       <= e_rd[sel_idx];
    issue.pc       <= e_pc[sel_idx];
    issue.imm      <= e_imm[sel_idx];
  end

endmodule

// File: rtl/phys_regfile.sv
`timescale 1ns/10ps

module phys_regfile import ooo_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [tag_w-1:0] rd_tag_a,
  input  logic [tag_w-1:0] rd_tag_b,
  output logic [xlen-1:0]  rd_data_a,
  output logic [xlen-1:0]  rd_data_b,
  result_bus_if.consumer   alu_bus,
  result_bus_if.consumer   ext_bus
);

  logic [xlen-1:0] regs [num_phys_regs];

  // Rename never lets both buses target the same tag in one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_phys_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (ext_bus.valid) begin
        regs[ext_bus.tag] <= ext_bus.data;
      end
      if (alu_bus.valid) begin
        regs[alu_bus.tag] <= alu_bus.data;
      end
    end
  end

  // Asynchronous reads for the ALU operand fetch.
  assign rd_data_a = regs[rd_tag_a];
  assign rd_data_b = regs[rd_tag_b];

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/10ps

module int_alu import ooo_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             flush,
  input  logic [xlen-1:0]  rd_data_a,
  input  logic [xlen-1:0]  rd_data_b,
  output logic [tag_w-1:0] rd_tag_a,
  output logic [tag_w-1:0] rd_tag_b,
  issue_if.executor        issue,
  result_bus_if.producer   alu_bus
);

  logic [xlen-1:0]    op_a;
  logic [xlen-1:0]    op_b;
  logic [xlen-1:0]    result;
  logic [shamt_w-1:0] shamt;

  assign rd_tag_a = issue.tag1;
  assign rd_tag_b = issue.tag2;

  assign op_a  = issue.src1_pc ? issue.pc : rd_data_a;
  assign op_b  = issue.src2_imm ? issue.imm : rd_data_b;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (issue.op)
      op_add:  result = op_a + op_b;
      op_sub:  result = op_a - op_b;
      op_and:  result = op_a & op_b;
      op_or:   result = op_a | op_b;
      op_xor:  result = op_a ^ op_b;
      op_sll:  result = op_a << shamt;
      op_srl:  result = op_a >> shamt;
      op_sra:  result = $unsigned($signed(op_a) >>> shamt);
      op_slt:  result = {{(xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      op_sltu: result = {{(xlen - 1){1'b0}}, op_a < op_b};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_bus.valid <= 1'b0;
    end else begin
      alu_bus.valid <= issue.valid && !flush;  // A flush drops the op in flight.
    end
  end

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      alu_bus.tag      <= issue.rd;
      alu_bus.data     <= result;
      alu_bus.inst_num <= issue.inst_num;
    end
  end

endmodule

// File: rtl/alu_cluster.sv
`timescale 1ns/10ps

module alu_cluster import ooo_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  flush,
  input  logic                  dispatch_valid,
  input  logic [inst_num_w-1:0] dispatch_inst_num,
  input  alu_op_e               dispatch_op,
  input  logic                  dispatch_src1_pc,
  input  logic                  dispatch_src2_imm,
  input  logic [tag_w-1:0]      dispatch_tag1,
  input  logic                  dispatch_rdy1,
  input  logic [tag_w-1:0]      dispatch_tag2,
  input  logic                  dispatch_rdy2,
  input  logic [tag_w-1:0]      dispatch_rd,
  input  logic [xlen-1:0]       dispatch_pc,
  input  logic [xlen-1:0]       dispatch_imm,
  input  logic                  ext_wb_valid,
  input  logic [tag_w-1:0]      ext_wb_tag,
  input  logic [xlen-1:0]       ext_wb_data,
  output logic                  dispatch_ready,
  output logic                  alu_wb_valid,
  output logic [tag_w-1:0]      alu_wb_tag,
  output logic [xlen-1:0]       alu_wb_data,
  output logic [inst_num_w-1:0] alu_wb_inst_num
);

  logic [tag_w-1:0] rd_tag_a;
  logic [tag_w-1:0] rd_tag_b;
  logic [xlen-1:0]  rd_data_a;
  logic [xlen-1:0]  rd_data_b;

  issue_if      issue ();
  result_bus_if alu_bus ();
  result_bus_if ext_bus ();

  // Merged writeback of the other functional units.
  assign ext_bus.valid    = ext_wb_valid;
  assign ext_bus.tag      = ext_wb_tag;
  assign ext_bus.data     = ext_wb_data;
  assign ext_bus.inst_num = '0;

  assign alu_wb_valid    = alu_bus.valid;
  assign alu_wb_tag      = alu_bus.tag;
  assign alu_wb_data     = alu_bus.data;
  assign alu_wb_inst_num = alu_bus.inst_num;

  alu_rs i_alu_rs (
    .clk               (clk),
    .arst_n            (arst_n),
    .flush             (flush),
    .dispatch_valid    (dispatch_valid),
    .dispatch_inst_num (dispatch_inst_num),
    .dispatch_op       (dispatch_op),
    .dispatch_src1_pc  (dispatch_src1_pc),
    .dispatch_src2_imm (dispatch_src2_imm),
    .dispatch_tag1     (dispatch_tag1),
    .dispatch_rdy1     (dispatch_rdy1),
    .dispatch_tag2     (dispatch_tag2),
    .dispatch_rdy2     (dispatch_rdy2),
    .dispatch_rd       (dispatch_rd),
    .dispatch_pc       (dispatch_pc),
    .dispatch_imm      (dispatch_imm),
    .dispatch_ready    (dispatch_ready),
    .issue             (issue.issuer),
    .alu_bus           (alu_bus.consumer),
    .ext_bus           (ext_bus.consumer)
  );

  phys_regfile i_phys_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_tag_a  (rd_tag_a),
    .rd_tag_b  (rd_tag_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .alu_bus   (alu_bus.consumer),
    .ext_bus   (ext_bus.consumer)
  );

  int_alu i_int_alu (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .rd_tag_a  (rd_tag_a),
    .rd_tag_b  (rd_tag_b),
    .issue     (issue.executor),
    .alu_bus   (alu_bus.producer)
  );

endmodule

// File: sim/alu_cluster_tb.sv
`timescale 1ns/10ps

module alu_cluster_tb import ooo_pkg::*; ();

  typedef struct packed {
    logic [3:0]       op;
    logic             src1_pc;
    logic             src2_imm;
    logic [tag_w-1:0] tag1;
    logic [tag_w-1:0] tag2;
    logic             wait1;  // Source 1 still waits for its writeback.
    logic             wait2;
    logic [tag_w-1:0] rd;
    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  imm;
  } pend_t;

  logic                  clk;
  logic                  arst_n;
  logic                  flush;
  logic                  dispatch_valid;
  logic [inst_num_w-1:0] dispatch_inst_num;
  alu_op_e               dispatch_op;
  logic                  dispatch_src1_pc;
  logic                  dispatch_src2_imm;
  logic [tag_w-1:0]      dispatch_tag1;
  logic                  dispatch_rdy1;
  logic [tag_w-1:0]      dispatch_tag2;
  logic                  dispatch_rdy2;
  logic [tag_w-1:0]      dispatch_rd;
  logic [xlen-1:0]       dispatch_pc;
  logic [xlen-1:0]       dispatch_imm;
  logic                  ext_wb_valid;
  logic [tag_w-1:0]      ext_wb_tag;
  logic [xlen-1:0]       ext_wb_data;
  logic                  dispatch_ready;
  logic                  alu_wb_valid;
  logic [tag_w-1:0]      alu_wb_tag;
  logic [xlen-1:0]       alu_wb_data;
  logic [inst_num_w-1:0] alu_wb_inst_num;

  logic [xlen-1:0] model_regs [num_phys_regs];
  pend_t           pend [256];  // Indexed by inst_num.
  logic            pend_valid [256];
  int              pend_count = 0;
  int              errors = 0;
  int              checked = 0;
  int              cycles = 0;
  int              limit = 0;

  alu_cluster i_alu_cluster (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Result rules for the ten opcodes, in enum order.
  function automatic logic [xlen-1:0] expected_result(input logic [3:0] op,
      input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    logic [2*xlen-1:0] wide;
    logic [4:0]        sh;
    sh   = b[4:0];
    wide = {{xlen{a[xlen-1]}}, a} >> sh;
    case (op)
      4'd0:    return a + b;
      4'd1:    return a - b;
      4'd2:    return a & b;
      4'd3:    return a | b;
      4'd4:    return a ^ b;
      4'd5:    return a << sh;
      4'd6:    return a >> sh;
      4'd7:    return wide[xlen-1:0];
      4'd8:    return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      4'd9:    return (a < b) ? 32'd1 : 32'd0;
      default: return 'x;
    endcase
  endfunction

  function automatic int count_cases();
    int    fd;
    int    n;
    string line;
    n  = 0;
    fd = $fopen("sim/alu_cluster_cases.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) inside {"W", "D", "F", "N"}) begin
          n++;
        end
      end
      $fclose(fd);
    end
    return n;
  endfunction

  // Pending instructions that still wait on a source tag, each holding a station entry.
  function automatic int waiting_count();
    int n;
    n = 0;
    for (int i = 0; i < 256; i++) begin
      if (pend_valid[i] && (pend[i].wait1 || pend[i].wait2)) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic idle_inputs();
    flush             = 1'b0;
    dispatch_valid    = 1'b0;
    dispatch_inst_num = '0;
    dispatch_op       = op_add;
    dispatch_src1_pc  = 1'b0;
    dispatch_src2_imm = 1'b0;
    dispatch_tag1     = '0;
    dispatch_rdy1     = 1'b0;
    dispatch_tag2     = '0;
    dispatch_rdy2     = 1'b0;
    dispatch_rd       = '0;
    dispatch_pc       = '0;
    dispatch_imm      = '0;
    ext_wb_valid      = 1'b0;
    ext_wb_tag        = '0;
    ext_wb_data       = '0;
  endtask

  // One command per falling edge; W, D and F hold for a single cycle.
  task automatic apply_command(input string line);
    byte         cmd;
    int          n;
    logic [31:0] v [11];
    n = $sscanf(line, "%c", cmd);
    if (n == 1 && cmd inside {"W", "D", "F", "N"}) begin
      @(negedge clk);
      idle_inputs();
      case (cmd)
        "W": begin
          n = $sscanf(line, "%c %h %h", cmd, v[0], v[1]);
          ext_wb_valid = 1'b1;
          ext_wb_tag   = v[0][tag_w-1:0];
          ext_wb_data  = v[1];
        end
        "D": begin
          n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h", cmd, v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
          dispatch_valid    = 1'b1;
          dispatch_inst_num = v[0];
          dispatch_op       = alu_op_e'(v[1][3:0]);
          dispatch_src1_pc  = v[2][0];
          dispatch_src2_imm = v[3][0];
          dispatch_tag1     = v[4][tag_w-1:0];
          dispatch_rdy1     = v[5][0];
          dispatch_tag2     = v[6][tag_w-1:0];
          dispatch_rdy2     = v[7][0];
          dispatch_rd       = v[8][tag_w-1:0];
          dispatch_pc       = v[9];
          dispatch_imm      = v[10];
        end
        "F": flush = 1'b1;
        default: begin
          n = $sscanf(line, "%c %h", cmd, v[0]);
          repeat (v[0]) @(negedge clk);
        end
      endcase
    end
  endtask

  // The station is full once every entry holds an instruction waiting on a tag.
  task automatic check_dispatch();
    logic exp_ready;
    exp_ready = (waiting_count() < rs_depth);
    if (dispatch_ready !== exp_ready) begin
      errors++;
      $display("ERROR %0t: inst %0h dispatch_ready %b, expected %b", $time,
               dispatch_inst_num, dispatch_ready, exp_ready);
    end
    if (exp_ready) begin
      pend[dispatch_inst_num[7:0]] = {dispatch_op, dispatch_src1_pc, dispatch_src2_imm,
          dispatch_tag1, dispatch_tag2, !dispatch_rdy1, !dispatch_rdy2, dispatch_rd,
          dispatch_pc, dispatch_imm};
      pend_valid[dispatch_inst_num[7:0]] = 1'b1;
      pend_count++;
    end
  endtask

  task automatic check_result();
    int              idx;
    pend_t           p;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] exp;
    if (alu_wb_inst_num > 255 || !pend_valid[alu_wb_inst_num[7:0]]) begin
      errors++;
      $display("Result at %0t for inst_num %0h, which is not pending", $time, alu_wb_inst_num);
    end else begin
      idx = alu_wb_inst_num;
      p   = pend[idx];
      a   = p.src1_pc ? p.pc : model_regs[p.tag1];
      b   = p.src2_imm ? p.imm : model_regs[p.tag2];
      exp = expected_result(p.op, a, b);
      checked++;
      if (p.wait1 || p.wait2) begin
        errors++;
        $display("Instruction %0h completed before its source tag was written", idx);
      end
      if (alu_wb_tag !== p.rd) begin
        errors++;
        $display("ERROR %0t: inst %0h tag %0h, expected %0h", $time, idx, alu_wb_tag, p.rd);
      end
      if (alu_wb_data !== exp) begin
        errors++;
        $display("ERROR %0t: inst %0h data %h, expected %h", $time, idx, alu_wb_data, exp);
      end
      pend_valid[idx] = 1'b0;
      pend_count--;
    end
  endtask

  task automatic write_model(input logic [tag_w-1:0] tag, input logic [xlen-1:0] data);
    model_regs[tag] = data;
    for (int i = 0; i < 256; i++) begin
      if (pend_valid[i] && pend[i].tag1 == tag) pend[i].wait1 = 1'b0;
      if (pend_valid[i] && pend[i].tag2 == tag) pend[i].wait2 = 1'b0;
    end
  endtask

  // Outputs and driven inputs are both settled at the rising edge.
  always @(posedge clk) begin
    if (arst_n) begin
      if (alu_wb_valid) check_result();
      if (dispatch_valid && !flush) check_dispatch();
      if (alu_wb_valid) write_model(alu_wb_tag, alu_wb_data);
      if (ext_wb_valid) write_model(ext_wb_tag, ext_wb_data);
      if (flush) begin
        for (int i = 0; i < 256; i++) pend_valid[i] = 1'b0;
        pend_count = 0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      errors++;
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Run finished with %0d results checked and %0d errors", checked, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin : main
    int    fd;
    int    drain;
    string line;
    for (int i = 0; i < 256; i++) pend_valid[i] = 1'b0;
    for (int i = 0; i < num_phys_regs; i++) model_regs[i] = '0;
    idle_inputs();
    arst_n = 1'b0;
    limit  = count_cases() * 20 + 1000;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    fd = $fopen("sim/alu_cluster_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file sim/alu_cluster_cases.txt");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) apply_command(line);
      $fclose(fd);
      @(negedge clk);
      idle_inputs();
      drain = 0;
      while (pend_count != 0 && drain < 100) begin
        @(negedge clk);
        drain++;
      end
      repeat (20) @(negedge clk);  // Room for any stray result to show up.
      for (int i = 0; i < 256; i++) begin
        if (pend_valid[i]) begin
          errors++;
          $display("Instruction %0h never produced a result", i);
        end
      end
      $display("Run finished with %0d results checked and %0d errors", checked, errors);
      if (errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: sim/alu_cluster_cases.txt
# W tag data | D inst op src1_pc src2_imm tag1 rdy1 tag2 rdy2 rd pc imm | F | N cycles
# All fields are hex; op is the numeric value of the ALU opcode enum.
W 01 00000064
W 02 FFFFFFF0
W 03 00000007
W 04 80000001
W 05 00000003
D 01 0 0 0 01 1 02 1 10 0 0
D 02 1 0 0 01 1 02 1 11 0 0
D 03 2 0 0 04 1 02 1 12 0 0
D 04 3 0 0 04 1 03 1 13 0 0
D 05 4 0 0 02 1 04 1 14 0 0
D 06 5 0 0 04 1 05 1 15 0 0
D 07 6 0 0 02 1 05 1 16 0 0
D 08 7 0 0 02 1 05 1 17 0 0
D 09 8 0 0 02 1 01 1 18 0 0
D 0A 9 0 0 02 1 01 1 19 0 0
D 0B 0 1 1 00 1 00 1 1A 1000 FFFFFFFC
D 0C 7 0 1 04 1 00 1 1B 0 21
N 8
D 20 0 0 0 20 0 01 1 30 0 0
D 21 1 0 0 01 1 03 1 31 0 0
D 22 4 0 0 30 0 03 1 32 0 0
D 23 5 0 0 32 0 05 1 33 0 0
N 6
W 20 12345678
N 10
D 40 0 0 0 28 0 03 1 08 0 0
D 41 1 0 0 28 0 03 1 09 0 0
D 42 2 0 0 28 0 03 1 0A 0 0
D 43 3 0 0 28 0 03 1 0B 0 0
D 44 4 0 0 28 0 03 1 0C 0 0
D 45 5 0 0 28 0 03 1 0D 0 0
D 46 6 0 0 28 0 03 1 0E 0 0
D 47 7 0 0 28 0 03 1 0F 0 0
D 48 0 0 0 03 1 03 1 3F 0 0
N 4
W 28 F0F0F0F0
N 20
D 50 0 0 0 29 0 01 1 34 0 0
D 51 1 0 0 01 1 03 1 35 0 0
F
W 29 00000055
D 52 3 0 0 01 1 03 1 36 0 0
N 10

// File: src.f
rtl/ooo_pkg.sv
rtl/issue_if.sv
rtl/result_bus_if.sv
rtl/alu_rs.sv
rtl/phys_regfile.sv
rtl/int_alu.sv
rtl/alu_cluster.sv
sim/alu_cluster_tb.sv

// File: Bender.yml
package:
  name: alu_cluster

sources:
  - rtl/ooo_pkg.sv
  - rtl/issue_if.sv
  - rtl/result_bus_if.sv
  - rtl/alu_rs.sv
  - rtl/phys_regfile.sv
  - rtl/int_alu.sv
  - rtl/alu_cluster.sv
  - target: simulation
    files:
      - sim/alu_cluster_tb.sv
